// ==== include/lbuff_macros.svh ====
`ifndef LBUFF_MACROS_SVH
`define LBUFF_MACROS_SVH

// Number of load buffer slots as a power of two
`define LBUFF_DEPTH 8

// Slot index bits
`define LBUFF_IDX_WIDTH $clog2(`LBUFF_DEPTH)

// Load id is the slot index plus a wrap bit
`define LBUFF_ID_WIDTH (`LBUFF_IDX_WIDTH + 1)

// ROB id with the MSB as wrap bit
`define ROB_ID_WIDTH 8

// Physical address
`define PADDR_WIDTH 44

`endif

// ==== verilog/lbuff_pkg.sv ====
`default_nettype none

`include "lbuff_macros.svh"

package lbuff_pkg;

    typedef logic [`LBUFF_IDX_WIDTH-1:0] lbuff_idx_t;
    typedef logic [`LBUFF_ID_WIDTH-1:0]  lbuff_id_t;
    typedef logic [`ROB_ID_WIDTH-1:0]    rob_id_t;
    typedef logic [`PADDR_WIDTH-1:0]     paddr_t;
    typedef logic [`LBUFF_DEPTH-1:0]     lbuff_vec_t;

    // True when a is older than b
    function automatic logic rob_older(input rob_id_t a, input rob_id_t b);
        logic wrap_diff;
        wrap_diff = a[`ROB_ID_WIDTH-1] ^ b[`ROB_ID_WIDTH-1];
        // Wrapped means the older one sits at the higher low bits
        if (wrap_diff) begin
            return a[`ROB_ID_WIDTH-2:0] >= b[`ROB_ID_WIDTH-2:0];
        end
        return a[`ROB_ID_WIDTH-2:0] < b[`ROB_ID_WIDTH-2:0];
    endfunction

endpackage

`default_nettype wire

// ==== verilog/lbuff_cmd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface lbuff_cmd_if import lbuff_pkg::*; ();

    // One-hot per slot
    lbuff_vec_t alloc_vec;
    lbuff_vec_t done_vec;
    lbuff_vec_t free_vec;

    // Broadcast to every slot
    rob_id_t    alloc_rob_id;
    paddr_t     done_paddr;
    logic       mis_flush;
    rob_id_t    mis_rob_id;
    logic       trap_flush;
    logic       st_vld;
    paddr_t     st_paddr;

    modport decode (
        output alloc_vec, done_vec, free_vec,
        output alloc_rob_id, done_paddr, mis_flush, mis_rob_id,
        output trap_flush, st_vld, st_paddr
    );

    modport entry (
        input alloc_vec, done_vec, free_vec,
        input alloc_rob_id, done_paddr, mis_flush, mis_rob_id,
        input trap_flush, st_vld, st_paddr
    );

endinterface

`default_nettype wire

// ==== verilog/lbuff_stat_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lbuff_macros.svh"

interface lbuff_stat_if import lbuff_pkg::*; ();

    // Store address hit per slot
    lbuff_vec_t match;

    // ROB id held by each slot
    rob_id_t    rob_id [`LBUFF_DEPTH];

    modport entry (
        output match,
        output rob_id
    );

    modport select (
        input match,
        input rob_id
    );

endinterface

`default_nettype wire

// ==== verilog/lbuff_cmd_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lbuff_macros.svh"

module lbuff_cmd_decode import lbuff_pkg::*; (
    input  wire              i_dsp_vld,
    input  wire lbuff_id_t   i_dsp_ld_id,
    input  wire rob_id_t     i_dsp_rob_id,

    input  wire              i_agu_vld,
    input  wire lbuff_id_t   i_agu_ld_id,
    input  wire paddr_t      i_agu_paddr,

    input  wire              i_ret_vld,
    input  wire lbuff_id_t   i_ret_ld_id,

    input  wire              i_trap_flush,
    input  wire              i_mis_flush,
    input  wire rob_id_t     i_mis_rob_id,

    input  wire              i_st_vld,
    input  wire paddr_t      i_st_paddr,

    lbuff_cmd_if.decode      cmd
);

    // Only the index bits pick a slot
    function automatic lbuff_vec_t slot_sel(input logic vld, input lbuff_id_t id);
        lbuff_vec_t vec;
        lbuff_idx_t idx;
        vec      = '0;
        idx      = id[`LBUFF_IDX_WIDTH-1:0];
        vec[idx] = vld;
        return vec;
    endfunction

    assign cmd.alloc_vec = slot_sel(i_dsp_vld, i_dsp_ld_id);
    assign cmd.done_vec  = slot_sel(i_agu_vld, i_agu_ld_id);
    assign cmd.free_vec  = slot_sel(i_ret_vld, i_ret_ld_id);

    assign cmd.alloc_rob_id = i_dsp_rob_id;
    assign cmd.done_paddr   = i_agu_paddr;

    assign cmd.mis_flush  = i_mis_flush;
    assign cmd.mis_rob_id = i_mis_rob_id;
    assign cmd.trap_flush = i_trap_flush;

    // Retiring store compared in every slot
    assign cmd.st_vld   = i_st_vld;
    assign cmd.st_paddr = i_st_paddr;

endmodule

`default_nettype wire

// ==== verilog/lbuff_entry.sv ====
`timescale 1ns/1ps
`default_nettype none

module lbuff_entry import lbuff_pkg::*; #(
    parameter int IDX = 0
) (
    input  wire          clk,
    input  wire          i_arst_n,
    lbuff_cmd_if.entry   cmd,
    lbuff_stat_if.entry  stat
);

    logic    valid_q;
    logic    done_q;
    rob_id_t rob_id_q;
    paddr_t  paddr_q;
    logic    flush_hit;
    logic    free_hit;

    // Mispredict drops only loads younger than the branch
    assign flush_hit = cmd.trap_flush
                     | (cmd.mis_flush & rob_older(cmd.mis_rob_id, rob_id_q));

    assign free_hit = cmd.free_vec[IDX] | flush_hit;

    // Free wins over alloc in the same cycle
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
            done_q  <= 1'b0;
        end else if (free_hit) begin
            valid_q <= 1'b0;
            done_q  <= 1'b0;
        end else if (cmd.alloc_vec[IDX]) begin
            valid_q <= 1'b1;
            done_q  <= 1'b0;
        end else if (cmd.done_vec[IDX]) begin
            done_q  <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.alloc_vec[IDX]) begin
            rob_id_q <= cmd.alloc_rob_id;
        end
    end

    // Address from the AGU
    always_ff @(posedge clk) begin
        if (cmd.done_vec[IDX]) begin
            paddr_q <= cmd.done_paddr;
        end
    end

    // Executed load hit by an older store
    assign stat.match[IDX] = valid_q & done_q & cmd.st_vld
                           & (cmd.st_paddr == paddr_q);

    assign stat.rob_id[IDX] = rob_id_q;

endmodule

`default_nettype wire

// ==== verilog/lbuff_violation_select.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lbuff_macros.svh"

module lbuff_violation_select import lbuff_pkg::*; (
    input  wire              clk,
    input  wire              i_arst_n,
    lbuff_stat_if.select     stat,
    input  wire lbuff_idx_t  i_ret_ptr,
    output logic             o_ls_flush,
    output rob_id_t          o_ls_rob_id
);

    lbuff_vec_t upper_mask;
    lbuff_vec_t upper_hit;
    lbuff_vec_t cand;
    lbuff_idx_t sel_idx;
    logic       any_hit;

    // Slots from the retire pointer upward are the oldest
    always_comb begin
        for (int i = 0; i < `LBUFF_DEPTH; i++) begin
            upper_mask[i] = (lbuff_idx_t'(i) >= i_ret_ptr);
        end
    end

    assign upper_hit = stat.match & upper_mask;
    assign any_hit   = |stat.match;

    // No hit above the pointer means the match wrapped below it
    assign cand = (|upper_hit) ? upper_hit : stat.match;

    // Lowest set bit
    always_comb begin
        sel_idx = '0;
        for (int i = `LBUFF_DEPTH - 1; i >= 0; i--) begin
            if (cand[i]) begin
                sel_idx = lbuff_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ls_flush  <= 1'b0;
            o_ls_rob_id <= '0;
        end else begin
            o_ls_flush  <= any_hit;
            o_ls_rob_id <= any_hit ? stat.rob_id[sel_idx] : '0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/load_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lbuff_macros.svh"

module load_buffer import lbuff_pkg::*; (
    input  wire              clk,
    input  wire              i_arst_n,

    // Dispatch
    input  wire              i_dsp_vld,
    input  wire lbuff_id_t   i_dsp_ld_id,
    input  wire rob_id_t     i_dsp_rob_id,

    // AGU writeback
    input  wire              i_agu_vld,
    input  wire lbuff_id_t   i_agu_ld_id,
    input  wire paddr_t      i_agu_paddr,

    // ROB retire
    input  wire              i_ret_vld,
    input  wire lbuff_id_t   i_ret_ld_id,
    input  wire lbuff_idx_t  i_ret_ptr,

    input  wire              i_trap_flush,
    input  wire              i_mis_flush,
    input  wire rob_id_t     i_mis_rob_id,

    // Store retire
    input  wire              i_st_vld,
    input  wire paddr_t      i_st_paddr,

    output logic             o_ls_flush,
    output rob_id_t          o_ls_rob_id
);

    lbuff_cmd_if  u_cmd_if ();
    lbuff_stat_if u_stat_if ();

    lbuff_cmd_decode u_cmd_decode (
        .i_dsp_vld    (i_dsp_vld),
        .i_dsp_ld_id  (i_dsp_ld_id),
        .i_dsp_rob_id (i_dsp_rob_id),
        .i_agu_vld    (i_agu_vld),
        .i_agu_ld_id  (i_agu_ld_id),
        .i_agu_paddr  (i_agu_paddr),
        .i_ret_vld    (i_ret_vld),
        .i_ret_ld_id  (i_ret_ld_id),
        .i_trap_flush (i_trap_flush),
        .i_mis_flush  (i_mis_flush),
        .i_mis_rob_id (i_mis_rob_id),
        .i_st_vld     (i_st_vld),
        .i_st_paddr   (i_st_paddr),
        .cmd          (u_cmd_if.decode)
    );

    for (genvar g = 0; g < `LBUFF_DEPTH; g++) begin : g_entry
        lbuff_entry #(
            .IDX (g)
        ) u_entry (
            .clk      (clk),
            .i_arst_n (i_arst_n),
            .cmd      (u_cmd_if.entry),
            .stat     (u_stat_if.entry)
        );
    end

    lbuff_violation_select u_violation_select (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .stat        (u_stat_if.select),
        .i_ret_ptr   (i_ret_ptr),
        .o_ls_flush  (o_ls_flush),
        .o_ls_rob_id (o_ls_rob_id)
    );

endmodule

`default_nettype wire

// ==== sim/tb_load_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lbuff_macros.svh"

module tb_load_buffer import lbuff_pkg::*; ();

    localparam int  DEPTH        = `LBUFF_DEPTH;
    localparam int  IW           = `LBUFF_IDX_WIDTH;
    localparam int  RW           = `ROB_ID_WIDTH;
    localparam int  RESET_CYCLES = 16;
    // Reset plus the cycles of tests 1 to 6
    localparam int  RUN_CYCLES   = RESET_CYCLES + 3 + 6 + 13 + 12 + 36 + 22;
    localparam real WATCHDOG_NS  = RUN_CYCLES * 4.0 + 200.0;

    logic       clk;
    logic       i_arst_n;
    logic       i_dsp_vld;
    lbuff_id_t  i_dsp_ld_id;
    rob_id_t    i_dsp_rob_id;
    logic       i_agu_vld;
    lbuff_id_t  i_agu_ld_id;
    paddr_t     i_agu_paddr;
    logic       i_ret_vld;
    lbuff_id_t  i_ret_ld_id;
    lbuff_idx_t i_ret_ptr;
    logic       i_trap_flush;
    logic       i_mis_flush;
    rob_id_t    i_mis_rob_id;
    logic       i_st_vld;
    paddr_t     i_st_paddr;
    logic       o_ls_flush;
    rob_id_t    o_ls_rob_id;

    integer     seed = 73052;
    string      test_name = "reset";
    int         errors;
    int         errors_at_start;
    int         tests_run;
    int         tests_failed;

    // Model of the slots
    logic       m_valid [DEPTH];
    logic       m_done  [DEPTH];
    rob_id_t    m_rob   [DEPTH];
    paddr_t     m_paddr [DEPTH];
    logic       exp_flush;
    rob_id_t    exp_rob_id;
    logic       model_hit;
    rob_id_t    model_hit_rob;
    int         slot;
    logic       slot_free;

    paddr_t     addr_a;
    paddr_t     addr_b;
    rob_id_t    rob_a;
    lbuff_idx_t ptrs [4] = '{3'd3, 3'd6, 3'd0, 3'd2};

    load_buffer u_load_buffer (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_dsp_vld    (i_dsp_vld),
        .i_dsp_ld_id  (i_dsp_ld_id),
        .i_dsp_rob_id (i_dsp_rob_id),
        .i_agu_vld    (i_agu_vld),
        .i_agu_ld_id  (i_agu_ld_id),
        .i_agu_paddr  (i_agu_paddr),
        .i_ret_vld    (i_ret_vld),
        .i_ret_ld_id  (i_ret_ld_id),
        .i_ret_ptr    (i_ret_ptr),
        .i_trap_flush (i_trap_flush),
        .i_mis_flush  (i_mis_flush),
        .i_mis_rob_id (i_mis_rob_id),
        .i_st_vld     (i_st_vld),
        .i_st_paddr   (i_st_paddr),
        .o_ls_flush   (o_ls_flush),
        .o_ls_rob_id  (o_ls_rob_id)
    );

    always #2 clk = ~clk;

    // Own slot is dropped when it is younger than the mispredicted id
    function automatic logic mis_kills(input rob_id_t mis, input rob_id_t own);
        if (mis[RW-1] == own[RW-1]) begin
            return own[RW-2:0] > mis[RW-2:0];
        end
        return own[RW-2:0] <= mis[RW-2:0];
    endfunction

    function automatic paddr_t rand_paddr();
        return paddr_t'({$random(seed), $random(seed)});
    endfunction

    always @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                m_valid[i] = 1'b0;
                m_done[i]  = 1'b0;
                m_rob[i]   = '0;
                m_paddr[i] = '0;
            end
            exp_flush  <= 1'b0;
            exp_rob_id <= '0;
        end else begin
            // Circular scan from the retire pointer finds the oldest hit
            model_hit     = 1'b0;
            model_hit_rob = '0;
            for (int k = 0; k < DEPTH; k++) begin
                slot = (int'(i_ret_ptr) + k) % DEPTH;
                if (!model_hit && i_st_vld && m_valid[slot] && m_done[slot]
                        && m_paddr[slot] == i_st_paddr) begin
                    model_hit     = 1'b1;
                    model_hit_rob = m_rob[slot];
                end
            end
            exp_flush  <= model_hit;
            exp_rob_id <= model_hit_rob;
            for (int i = 0; i < DEPTH; i++) begin
                slot_free = i_trap_flush
                          || (i_mis_flush && mis_kills(i_mis_rob_id, m_rob[i]))
                          || (i_ret_vld && i_ret_ld_id[IW-1:0] == lbuff_idx_t'(i));
                if (i_dsp_vld && i_dsp_ld_id[IW-1:0] == lbuff_idx_t'(i)) begin
                    m_rob[i] = i_dsp_rob_id;
                end
                if (i_agu_vld && i_agu_ld_id[IW-1:0] == lbuff_idx_t'(i)) begin
                    m_paddr[i] = i_agu_paddr;
                end
                if (slot_free) begin
                    m_valid[i] = 1'b0;
                    m_done[i]  = 1'b0;
                end else if (i_dsp_vld && i_dsp_ld_id[IW-1:0] == lbuff_idx_t'(i)) begin
                    m_valid[i] = 1'b1;
                    m_done[i]  = 1'b0;
                end else if (i_agu_vld && i_agu_ld_id[IW-1:0] == lbuff_idx_t'(i)) begin
                    m_done[i]  = 1'b1;
                end
            end
        end
    end

    flush_vs_model: assert property (@(negedge clk) o_ls_flush == exp_flush)
        else begin
            $display("[ERROR] %s: o_ls_flush expected %0b actual %0b",
                     test_name, exp_flush, o_ls_flush);
            errors++;
        end

    rob_id_vs_model: assert property (@(negedge clk) exp_flush |-> o_ls_rob_id == exp_rob_id)
        else begin
            $display("[ERROR] %s: o_ls_rob_id expected %h actual %h",
                     test_name, exp_rob_id, o_ls_rob_id);
            errors++;
        end

    task automatic start_cycle();
        @(posedge clk);
        #0.5;
        i_dsp_vld    = 1'b0;
        i_agu_vld    = 1'b0;
        i_ret_vld    = 1'b0;
        i_trap_flush = 1'b0;
        i_mis_flush  = 1'b0;
        i_st_vld     = 1'b0;
    endtask

    task automatic alloc_slot(input int idx, input rob_id_t rob);
        start_cycle();
        i_dsp_vld    = 1'b1;
        i_dsp_ld_id  = {1'b0, lbuff_idx_t'(idx)};
        i_dsp_rob_id = rob;
    endtask

    // A set wrap bit must not change the selected slot
    task automatic mark_done(input int idx, input paddr_t addr);
        start_cycle();
        i_agu_vld   = 1'b1;
        i_agu_ld_id = {1'b1, lbuff_idx_t'(idx)};
        i_agu_paddr = addr;
    endtask

    task automatic retire_slot(input int idx);
        start_cycle();
        i_ret_vld   = 1'b1;
        i_ret_ld_id = {1'b1, lbuff_idx_t'(idx)};
    endtask

    task automatic trap_all();
        start_cycle();
        i_trap_flush = 1'b1;
    endtask

    task automatic store_check(input paddr_t addr, input logic want_hit);
        start_cycle();
        i_st_vld   = 1'b1;
        i_st_paddr = addr;
        start_cycle();
        assert (o_ls_flush == want_hit)
        else begin
            $display("[ERROR] %s: flush for store %h expected %0b actual %0b",
                     test_name, addr, want_hit, o_ls_flush);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        start_cycle();
        start_cycle();
        if (errors == errors_at_start) begin
            $display("Test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("Test %s failed", test_name);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        clk = 1'b0;
        i_arst_n = 1'b1;
        i_dsp_vld = 1'b0;
        i_dsp_ld_id = '0;
        i_dsp_rob_id = '0;
        i_agu_vld = 1'b0;
        i_agu_ld_id = '0;
        i_agu_paddr = '0;
        i_ret_vld = 1'b0;
        i_ret_ld_id = '0;
        i_ret_ptr = '0;
        i_trap_flush = 1'b0;
        i_mis_flush = 1'b0;
        i_mis_rob_id = '0;
        i_st_vld = 1'b0;
        i_st_paddr = '0;
        #1 i_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #0.5 i_arst_n = 1'b1;

        begin_test("reset_state");
        @(negedge clk);
        assert (o_ls_flush == 1'b0 && o_ls_rob_id == '0)
        else begin
            $display("[ERROR] %s: flush/rob id expected 0/00 actual %0b/%h",
                     test_name, o_ls_flush, o_ls_rob_id);
            errors++;
        end
        end_test();

        begin_test("single_hit");
        rob_a  = rob_id_t'($random(seed));
        addr_a = rand_paddr();
        alloc_slot(4, rob_a);
        mark_done(4, addr_a);
        store_check(addr_a, 1'b1);
        end_test();

        begin_test("no_hit");
        trap_all();
        addr_a = rand_paddr();
        addr_b = addr_a ^ paddr_t'(1);
        alloc_slot(0, rob_id_t'($random(seed)));
        mark_done(0, addr_a);
        store_check(addr_b, 1'b0);
        // Realloc keeps the old address but clears done
        alloc_slot(1, rob_id_t'($random(seed)));
        mark_done(1, addr_b);
        retire_slot(1);
        alloc_slot(1, rob_id_t'($random(seed)));
        store_check(addr_b, 1'b0);
        end_test();

        begin_test("released");
        addr_a = rand_paddr();
        addr_b = rand_paddr();
        alloc_slot(2, rob_id_t'($random(seed)));
        mark_done(2, addr_a);
        retire_slot(2);
        store_check(addr_a, 1'b0);
        alloc_slot(3, rob_id_t'($random(seed)));
        mark_done(3, addr_b);
        trap_all();
        store_check(addr_b, 1'b0);
        end_test();

        begin_test("mispredict");
        trap_all();
        addr_a = rand_paddr();
        // Ids fc to ff then 00 to 03 so the ROB id wraps around at slot 4
        for (int i = 0; i < DEPTH; i++) begin
            alloc_slot(i, rob_id_t'(8'hfc + i));
            mark_done(i, addr_a + paddr_t'(i));
        end
        start_cycle();
        i_mis_flush  = 1'b1;
        i_mis_rob_id = 8'hfe;
        for (int i = 0; i < DEPTH; i++) begin
            store_check(addr_a + paddr_t'(i), i < 3);
        end
        end_test();

        begin_test("oldest_select");
        trap_all();
        rob_a  = rob_id_t'($random(seed));
        addr_a = rand_paddr();
        for (int i = 0; i < DEPTH; i++) begin
            alloc_slot(i, rob_a + rob_id_t'(i));
        end
        mark_done(1, addr_a);
        mark_done(2, addr_a);
        mark_done(5, addr_a);
        for (int p = 0; p < 4; p++) begin
            i_ret_ptr = ptrs[p];
            store_check(addr_a, 1'b1);
        end
        end_test();

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
verilog/lbuff_pkg.sv
verilog/lbuff_cmd_if.sv
verilog/lbuff_stat_if.sv
verilog/lbuff_cmd_decode.sv
verilog/lbuff_entry.sv
verilog/lbuff_violation_select.sv
verilog/load_buffer.sv
sim/tb_load_buffer.sv

// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP    ?= tb_load_buffer
RTL_TOP   ?= load_buffer
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^Finished with no errors$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
